/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := issue_stage_tb
FILELIST := issue_stage.f
BUILD    := obj_dir
PASS     := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

/* issue_stage.f */
source/ooo_pkg.sv
source/gpr_file.sv
source/issue.sv
source/scoreboard.sv
source/commit.sv
source/issue_stage.sv
tests/clock_gen.sv
tests/issue_stage_tb.sv

/* source/commit.sv */
`timescale 1ns/1ps

module commit (
  input  logic                                       clock,
  input  logic                                       rst,
  input  logic                                       head_valid,
  input  ooo_pkg::decoder_t                          head_instr,
  input  ooo_pkg::word_t                             head_result,
  output logic                                       commit_pop,
  output logic                                       gpr_we,
  output ooo_pkg::reg_addr_t                         gpr_waddr,
  output ooo_pkg::word_t                             gpr_wdata,
  input  ooo_pkg::writeback_t [ooo_pkg::wb_ports-1:0] wb,
  input  logic                                       branch_taken,
  input  ooo_pkg::addr_t                             branch_address,
  output logic                                       retire_valid,
  output logic                                       retire_branch,
  output logic                                       retire_jump,
  output logic                                       retire_is_rv16,
  output ooo_pkg::addr_t                             retire_pc,
  output ooo_pkg::addr_t                             retire_dnpc,
  output ooo_pkg::reg_addr_t                         retire_rd,
  output ooo_pkg::word_t                             retire_wdata
);
  import ooo_pkg::*;

  trans_id_t head_id_q; // Tracks scoreboard head
  logic      taken_q [sb_depth];
  addr_t     target_q [sb_depth];
  logic      is_branch;
  logic      is_jump;

  // Register file is written on the same edge the entry frees
  assign commit_pop = head_valid;
  assign gpr_we = head_valid && head_instr.rd != '0 && head_instr.op != LSU_SW;
  assign gpr_waddr = head_instr.rd;
  assign gpr_wdata = head_result;

  assign is_jump = head_instr.op inside {BJU_JAL, BJU_JALR};
  assign is_branch = head_instr.fu == FU_BJU && (head_instr.op inside {ALU_EQ, ALU_NE, ALU_LT});

  always_ff @(posedge clock) begin
    if (rst) begin
      head_id_q <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit_pop;
      if (commit_pop) begin
        head_id_q <= head_id_q + 1'b1;
      end
    end
  end

  // Branch outcome kept per entry since results come back out of order
  always_ff @(posedge clock) begin
    if (wb[0].valid) begin
      taken_q[wb[0].trans_id] <= branch_taken;
      target_q[wb[0].trans_id] <= branch_address;
    end
  end

  always_ff @(posedge clock) begin
    if (commit_pop) begin
      retire_pc <= head_instr.pc;
      retire_is_rv16 <= head_instr.is_rv16;
      retire_rd <= head_instr.rd;
      retire_wdata <= head_result;
      retire_jump <= is_jump;
      retire_branch <= is_branch && taken_q[head_id_q];
      if (head_instr.fu == FU_BJU) begin
        retire_dnpc <= target_q[head_id_q];
      end else begin
        retire_dnpc <= head_instr.pc + (head_instr.is_rv16 ? 32'd2 : 32'd4);
      end
    end
  end

endmodule

/* source/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
  input  logic               clock,
  input  logic               rst,
  input  ooo_pkg::reg_addr_t rs1,
  input  ooo_pkg::reg_addr_t rs2,
  output ooo_pkg::word_t     rdata1,
  output ooo_pkg::word_t     rdata2,
  input  logic               gpr_we,
  input  ooo_pkg::reg_addr_t gpr_waddr,
  input  ooo_pkg::word_t     gpr_wdata
);
  import ooo_pkg::*;

  word_t regs_q [32];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (gpr_we && gpr_waddr != '0) begin // x0 ignores writes
      regs_q[gpr_waddr] <= gpr_wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs_q[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs_q[rs2];

endmodule

/* source/issue.sv */
`timescale 1ns/1ps

module issue (
  input  logic                     clock,
  input  logic                     rst,
  input  ooo_pkg::decoder_t        idu2isu_instr,
  input  logic                     idu_valid,
  output logic                     isu2idu_ready,
  input  logic                     flush_unissued_instr,
  output ooo_pkg::fwd_query_t [1:0] fwd_query,
  input  ooo_pkg::fwd_reply_t [1:0] fwd_reply,
  output ooo_pkg::reg_addr_t       rs1,
  output ooo_pkg::reg_addr_t       rs2,
  input  ooo_pkg::word_t           rdata1,
  input  ooo_pkg::word_t           rdata2,
  output logic                     alloc,
  input  logic                     alloc_ready,
  output ooo_pkg::decoder_t        alloc_instr,
  input  ooo_pkg::trans_id_t       alloc_id,
  output ooo_pkg::fu_data_t        fu_data,
  output ooo_pkg::addr_t           pc,
  output logic                     is_rv16,
  input  logic                     flu_ready,
  input  logic                     lsu_ready,
  output logic                     alu_valid,
  output logic                     bju_valid,
  output logic                     lsu_valid
);
  import ooo_pkg::*;

  decoder_t instr_q;
  logic     valid_q;
  logic     can_go;
  logic     fire;
  logic     accept;

  assign rs1 = instr_q.rs1;
  assign rs2 = instr_q.rs2;
  assign pc = instr_q.pc;
  assign is_rv16 = instr_q.is_rv16;

  always_comb begin
    fwd_query[0].rs = instr_q.rs1;
    fwd_query[0].valid = valid_q;
    fwd_query[1].rs = instr_q.rs2;
    fwd_query[1].valid = valid_q && !instr_q.use_imm; // No rs2 dependency with an immediate
  end

  // Scoreboard result wins over the register file
  always_comb begin
    fu_data.fu = instr_q.fu;
    fu_data.op = instr_q.op;
    fu_data.operand_a = fwd_reply[0].hit ? fwd_reply[0].data : rdata1;
    if (instr_q.use_imm) begin
      fu_data.operand_b = instr_q.imm;
    end else begin
      fu_data.operand_b = fwd_reply[1].hit ? fwd_reply[1].data : rdata2;
    end
    fu_data.imm = instr_q.imm;
    fu_data.trans_id = alloc_id;
  end

  assign can_go = valid_q && !flush_unissued_instr && alloc_ready &&
                  !fwd_reply[0].busy && !fwd_reply[1].busy;

  assign alu_valid = can_go && (instr_q.fu inside {FU_ALU, FU_NONE});
  assign bju_valid = can_go && instr_q.fu == FU_BJU;
  assign lsu_valid = can_go && instr_q.fu == FU_LSU;

  assign fire = ((alu_valid || bju_valid) && flu_ready) || (lsu_valid && lsu_ready);
  assign alloc = fire;
  assign alloc_instr = instr_q;

  assign isu2idu_ready = (!valid_q || fire) && !flush_unissued_instr;
  assign accept = idu_valid && isu2idu_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush_unissued_instr) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      instr_q <= idu2isu_instr;
    end
  end

  a_one_unit: assert property (@(posedge clock) disable iff (rst)
    $onehot0({alu_valid, bju_valid, lsu_valid}));

endmodule

/* source/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic                                       clock,
  input  logic                                       rst,
  input  ooo_pkg::decoder_t                          idu2isu_instr,
  input  logic                                       idu_valid,
  output logic                                       isu2idu_ready,
  input  logic                                       flush_unissued_instr,
  output ooo_pkg::fu_data_t                          fu_data,
  output ooo_pkg::addr_t                             pc,
  output logic                                       is_rv16,
  input  logic                                       flu_ready,
  input  logic                                       lsu_ready,
  output logic                                       alu_valid,
  output logic                                       bju_valid,
  output logic                                       lsu_valid,
  input  ooo_pkg::writeback_t [ooo_pkg::wb_ports-1:0] wb,
  input  logic                                       branch_taken,
  input  ooo_pkg::addr_t                             branch_address,
  output logic                                       retire_valid,
  output logic                                       retire_branch,
  output logic                                       retire_jump,
  output logic                                       retire_is_rv16,
  output ooo_pkg::addr_t                             retire_pc,
  output ooo_pkg::addr_t                             retire_dnpc,
  output ooo_pkg::reg_addr_t                         retire_rd,
  output ooo_pkg::word_t                             retire_wdata
);
  import ooo_pkg::*;

  // Operand lookup
  fwd_query_t [1:0] fwd_query;
  fwd_reply_t [1:0] fwd_reply;
  reg_addr_t        rs1;
  reg_addr_t        rs2;
  word_t            rdata1;
  word_t            rdata2;

  // Allocation
  logic      alloc;
  logic      alloc_ready;
  decoder_t  alloc_instr;
  trans_id_t alloc_id;

  // Retirement
  logic      head_valid;
  decoder_t  head_instr;
  word_t     head_result;
  logic      commit_pop;
  logic      gpr_we;
  reg_addr_t gpr_waddr;
  word_t     gpr_wdata;

  issue issue_inst (.*);

  scoreboard scoreboard_inst (.*);

  commit commit_inst (.*);

  gpr_file gpr_file_inst (.*);

endmodule

/* source/ooo_pkg.sv */
package ooo_pkg;

  localparam int sb_depth = 4;
  localparam int trans_id_bits = 2; // Index into the scoreboard
  localparam int wb_ports = 2;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [trans_id_bits-1:0] trans_id_t;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_BJU,
    FU_LSU
  } fu_e;

  // Compare ops double as branch conditions on the BJU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    BJU_JAL,
    BJU_JALR,
    LSU_LW,
    LSU_SW
  } fu_op_e;

  typedef enum logic [1:0] {
    FREE,
    ISSUED,
    DONE
  } sb_state_e;

  typedef struct packed {
    addr_t     pc;
    logic      is_rv16;
    fu_e       fu;
    fu_op_e    op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_imm; // operand_b takes imm
    word_t     imm;
  } decoder_t;

  typedef struct packed {
    fu_e       fu;
    fu_op_e    op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    word_t     result;
  } writeback_t;

  typedef struct packed {
    reg_addr_t rs;
    logic      valid;
  } fwd_query_t;

  typedef struct packed {
    logic  busy; // Producer still in flight
    logic  hit;  // Result waiting in scoreboard
    word_t data;
  } fwd_reply_t;

endpackage

/* source/scoreboard.sv */
`timescale 1ns/1ps

module scoreboard (
  input  logic                                       clock,
  input  logic                                       rst,
  input  logic                                       alloc,
  input  ooo_pkg::decoder_t                          alloc_instr,
  output logic                                       alloc_ready,
  output ooo_pkg::trans_id_t                         alloc_id,
  input  ooo_pkg::writeback_t [ooo_pkg::wb_ports-1:0] wb,
  input  ooo_pkg::fwd_query_t [1:0]                  fwd_query,
  output ooo_pkg::fwd_reply_t [1:0]                  fwd_reply,
  output logic                                       head_valid,
  output ooo_pkg::decoder_t                          head_instr,
  output ooo_pkg::word_t                             head_result,
  input  logic                                       commit_pop
);
  import ooo_pkg::*;

  sb_state_e state_q [sb_depth];
  decoder_t  instr_q [sb_depth];
  word_t     result_q [sb_depth];
  trans_id_t head_q;
  trans_id_t tail_q;
  logic      do_alloc;
  logic      do_pop;

  // Full when the tail has wrapped onto a live entry
  assign alloc_ready = state_q[tail_q] == FREE;
  assign alloc_id = tail_q;
  assign do_alloc = alloc && alloc_ready;

  assign head_valid = state_q[head_q] == DONE;
  assign head_instr = instr_q[head_q];
  assign head_result = result_q[head_q];
  assign do_pop = commit_pop && head_valid;

  // Walk oldest to youngest so the last match is the youngest producer
  always_comb begin
    trans_id_t idx;
    for (int q = 0; q < 2; q++) begin
      fwd_reply[q] = '0;
      for (int i = 0; i < sb_depth; i++) begin
        idx = head_q + trans_id_t'(i);
        if (fwd_query[q].valid && fwd_query[q].rs != '0 && state_q[idx] != FREE &&
            instr_q[idx].rd == fwd_query[q].rs) begin
          fwd_reply[q].busy = state_q[idx] == ISSUED;
          fwd_reply[q].hit = state_q[idx] == DONE;
          fwd_reply[q].data = result_q[idx];
        end
      end
    end
  end

  // Writeback, alloc and pop always touch different entries
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < sb_depth; i++) begin
        state_q[i] <= FREE;
      end
      head_q <= '0;
      tail_q <= '0;
    end else begin
      for (int p = 0; p < wb_ports; p++) begin
        if (wb[p].valid) begin
          state_q[wb[p].trans_id] <= DONE;
        end
      end
      if (do_alloc) begin
        state_q[tail_q] <= ISSUED;
        tail_q <= tail_q + 1'b1;
      end
      if (do_pop) begin
        state_q[head_q] <= FREE;
        head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_alloc) begin
      instr_q[tail_q] <= alloc_instr;
    end
    for (int p = 0; p < wb_ports; p++) begin
      if (wb[p].valid) begin
        result_q[wb[p].trans_id] <= wb[p].result;
      end
    end
  end

  for (genvar p = 0; p < wb_ports; p++) begin : g_wb_check
    a_wb_live: assert property (@(posedge clock) disable iff (rst)
      wb[p].valid |-> state_q[wb[p].trans_id] == ISSUED);
  end

  // Issue must respect alloc_ready
  a_no_overflow: assert property (@(posedge clock) disable iff (rst)
    alloc |-> state_q[tail_q] == FREE);

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
  parameter int period = 20,
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(negedge clock);
    rst = 1'b0;
  end

endmodule

/* tests/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb;
  import ooo_pkg::*;

  localparam int period = 20;

  typedef struct packed {
    decoder_t instr;
    logic     flush; // Dropped while still in the issue unit
    word_t    exp_wdata;
    logic     exp_branch;
    logic     exp_jump;
    addr_t    exp_dnpc;
  } row_t;

  // One result on its way back from a functional unit
  typedef struct packed {
    trans_id_t id;
    word_t     result;
    logic      taken;
    addr_t     target;
    logic      bju;
    int        due;
  } pending_t;

  logic                           clock;
  logic                           rst;
  decoder_t                       idu2isu_instr;
  logic                           idu_valid;
  logic                           isu2idu_ready;
  logic                           flush_unissued_instr;
  fu_data_t                       fu_data;
  addr_t                          pc;
  logic                           is_rv16;
  logic                           flu_ready;
  logic                           lsu_ready;
  logic                           alu_valid;
  logic                           bju_valid;
  logic                           lsu_valid;
  writeback_t [wb_ports-1:0]      wb;
  logic                           branch_taken;
  addr_t                          branch_address;
  logic                           retire_valid;
  logic                           retire_branch;
  logic                           retire_jump;
  logic                           retire_is_rv16;
  addr_t                          retire_pc;
  addr_t                          retire_dnpc;
  reg_addr_t                      retire_rd;
  word_t                          retire_wdata;

  row_t     table_q [$];
  int       exp_rows [$]; // Table rows expected to retire, in order
  pending_t pending [$];
  int       seed = 49107;
  int       errors = 0;
  int       checks = 0;
  int       cycle = 0;
  int       row_idx = 0;
  int       ret_idx = 0;
  int       retired = 0;
  int       dispatched = 0;
  logic     flush_pending = 1'b0;

  clock_gen clock_gen_inst (.clock(clock), .rst(rst));

  issue_stage issue_stage_inst (.*);

  function automatic logic compare_holds(fu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ: return a == b;
      ALU_NE: return a != b;
      ALU_LT: return $signed(a) < $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t unit_result(fu_op_e op, word_t a, word_t b, word_t imm, addr_t pc_v);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_EQ, ALU_NE, ALU_LT: return {31'b0, compare_holds(op, a, b)};
      BJU_JAL, BJU_JALR: return pc_v + 32'd4; // Link address
      LSU_LW: return a + imm;
      default: return '0;
    endcase
  endfunction

  function automatic addr_t jump_target(fu_op_e op, word_t a, word_t imm, addr_t pc_v);
    return (op == BJU_JALR) ? a + imm : pc_v + imm;
  endfunction

  task automatic add_row(input fu_e fu, input fu_op_e op, input reg_addr_t rs1,
                         input reg_addr_t rs2, input reg_addr_t rd, input logic use_imm,
                         input word_t imm, input logic rv16, input logic flush);
    row_t r;
    r = '0;
    r.instr.pc = 32'h1000 + 32'(table_q.size() * 4);
    r.instr.is_rv16 = rv16;
    r.instr.fu = fu;
    r.instr.op = op;
    r.instr.rs1 = rs1;
    r.instr.rs2 = rs2;
    r.instr.rd = rd;
    r.instr.use_imm = use_imm;
    r.instr.imm = imm;
    r.flush = flush;
    table_q.push_back(r);
  endtask

  task automatic fill_table();
    add_row(FU_ALU, ALU_ADD, 5'd0, 5'd0, 5'd1, 1'b1, 32'd5, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_ADD, 5'd1, 5'd0, 5'd2, 1'b1, 32'd7, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_SUB, 5'd2, 5'd1, 5'd3, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_XOR, 5'd3, 5'd2, 5'd4, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(FU_LSU, LSU_LW, 5'd4, 5'd0, 5'd5, 1'b1, 32'h100, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_ADD, 5'd5, 5'd0, 5'd0, 1'b1, 32'd1, 1'b0, 1'b0); // Lost in x0
    add_row(FU_ALU, ALU_ADD, 5'd0, 5'd3, 5'd6, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_LT, 5'd1, 5'd2, 5'd7, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(FU_BJU, ALU_EQ, 5'd3, 5'd6, 5'd0, 1'b0, 32'h20, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_ADD, 5'd1, 5'd0, 5'd8, 1'b1, 32'd100, 1'b0, 1'b1);
    add_row(FU_BJU, ALU_NE, 5'd1, 5'd1, 5'd0, 1'b0, 32'h40, 1'b0, 1'b0);
    add_row(FU_BJU, BJU_JAL, 5'd0, 5'd0, 5'd9, 1'b1, 32'h80, 1'b0, 1'b0);
    add_row(FU_LSU, LSU_SW, 5'd9, 5'd5, 5'd0, 1'b0, 32'd8, 1'b0, 1'b0);
    add_row(FU_BJU, BJU_JALR, 5'd2, 5'd0, 5'd10, 1'b1, 32'd4, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_ADD, 5'd10, 5'd9, 5'd11, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(FU_ALU, ALU_LT, 5'd8, 5'd11, 5'd12, 1'b0, 32'd0, 1'b1, 1'b0);
  endtask

  // Golden in-order execution fills the expected columns
  task automatic build_expected();
    word_t regs [32];
    row_t  r;
    word_t a;
    word_t b;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < table_q.size(); i++) begin
      r = table_q[i];
      if (!r.flush) begin
        a = regs[r.instr.rs1];
        b = r.instr.use_imm ? r.instr.imm : regs[r.instr.rs2];
        r.exp_wdata = unit_result(r.instr.op, a, b, r.instr.imm, r.instr.pc);
        r.exp_branch = r.instr.fu == FU_BJU && compare_holds(r.instr.op, a, b);
        r.exp_jump = r.instr.op inside {BJU_JAL, BJU_JALR};
        if (r.instr.fu == FU_BJU) begin
          r.exp_dnpc = jump_target(r.instr.op, a, r.instr.imm, r.instr.pc);
        end else begin
          r.exp_dnpc = r.instr.pc + (r.instr.is_rv16 ? 32'd2 : 32'd4);
        end
        if (r.instr.rd != '0 && r.instr.op != LSU_SW) begin
          regs[r.instr.rd] = r.exp_wdata;
        end
        table_q[i] = r;
        exp_rows.push_back(i);
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // BJU results go out on port 0, which carries the branch outcome
  task automatic drive_writebacks();
    pending_t   p;
    int         port;
    int         i;
    logic [1:0] used;
    wb = '0;
    branch_taken = 1'b0;
    branch_address = '0;
    used = '0;
    i = 0;
    while (i < pending.size()) begin
      p = pending[i];
      if (p.due <= cycle) begin
        port = p.bju ? 0 : int'({$random(seed)} % 2);
        if (used[port] && !p.bju) begin
          port = 1 - port;
        end
        if (!used[port]) begin
          used[port] = 1'b1;
          wb[port].valid = 1'b1;
          wb[port].trans_id = p.id;
          wb[port].result = p.result;
          if (port == 0) begin
            branch_taken = p.taken;
            branch_address = p.target;
          end
          pending.delete(i);
          continue;
        end
      end
      i++;
    end
  endtask

  task automatic drive_inputs();
    if (flush_pending) begin
      flush_unissued_instr = 1'b1;
      flu_ready = 1'b0; // Units held off so the row cannot leave
      lsu_ready = 1'b0;
      idu_valid = 1'b0;
      flush_pending = 1'b0;
    end else begin
      flush_unissued_instr = 1'b0;
      flu_ready = ({$random(seed)} % 4) != 0;
      lsu_ready = ({$random(seed)} % 3) != 0;
      idu_valid = row_idx < table_q.size();
      if (idu_valid) begin
        idu2isu_instr = table_q[row_idx].instr;
      end
    end
    drive_writebacks();
  endtask

  task automatic record_dispatch();
    pending_t p;
    row_t     r;
    if (dispatched < exp_rows.size()) begin
      r = table_q[exp_rows[dispatched]]; // Issue leaves in program order
      check_value("pc", pc, r.instr.pc);
      check_value("is_rv16", 32'(is_rv16), 32'(r.instr.is_rv16));
      check_value("bju_valid", 32'(bju_valid), 32'(r.instr.fu == FU_BJU));
      check_value("lsu_valid", 32'(lsu_valid), 32'(r.instr.fu == FU_LSU));
    end
    p.id = fu_data.trans_id;
    p.result = unit_result(fu_data.op, fu_data.operand_a, fu_data.operand_b, fu_data.imm, pc);
    p.bju = fu_data.fu == FU_BJU;
    p.taken = compare_holds(fu_data.op, fu_data.operand_a, fu_data.operand_b);
    p.target = jump_target(fu_data.op, fu_data.operand_a, fu_data.imm, pc);
    p.due = cycle + 1 + int'({$random(seed)} % 6);
    pending.push_back(p);
    dispatched++;
  endtask

  task automatic check_retire();
    row_t r;
    if (ret_idx >= exp_rows.size()) begin
      errors++;
      $display("An instruction retired after every expected row had already retired");
      return;
    end
    r = table_q[exp_rows[ret_idx]];
    check_value("retire_pc", retire_pc, r.instr.pc);
    check_value("retire_rd", 32'(retire_rd), 32'(r.instr.rd));
    check_value("retire_wdata", retire_wdata, r.exp_wdata);
    check_value("retire_branch", 32'(retire_branch), 32'(r.exp_branch));
    check_value("retire_jump", 32'(retire_jump), 32'(r.exp_jump));
    check_value("retire_is_rv16", 32'(retire_is_rv16), 32'(r.instr.is_rv16));
    check_value("retire_dnpc", retire_dnpc, r.exp_dnpc);
    ret_idx++;
  endtask

  // Inputs change on the falling edge, outputs are read once they settle
  task automatic step_cycle();
    @(negedge clock);
    cycle++;
    drive_inputs();
    #1;
    if (idu_valid && isu2idu_ready) begin
      flush_pending = table_q[row_idx].flush;
      row_idx++;
    end
    if (((alu_valid || bju_valid) && flu_ready) || (lsu_valid && lsu_ready)) begin
      record_dispatch();
    end
    if (retire_valid) begin
      retired++;
      check_retire();
    end
  endtask

  initial begin
    idu2isu_instr = '0;
    idu_valid = 1'b0;
    flush_unissued_instr = 1'b0;
    flu_ready = 1'b0;
    lsu_ready = 1'b0;
    wb = '0;
    branch_taken = 1'b0;
    branch_address = '0;
    fill_table();
    build_expected();
    @(negedge rst);
    while (ret_idx < exp_rows.size()) begin
      step_cycle();
    end
    repeat (10) step_cycle(); // Catch any stray retirement
    check_value("retire_count", 32'(retired), 32'(exp_rows.size()));
    check_value("dispatch_count", 32'(dispatched), 32'(exp_rows.size()));
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #1;
    #(table_q.size() * 200 * period);
    $display("Timed out after %0d cycles with %0d of %0d instructions retired",
             cycle, ret_idx, exp_rows.size());
    $display("Testbench failed");
    $finish;
  end

endmodule
